/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0
TOP       := decodeStageTb
FILELIST  := filelist.f
OBJDIR    := obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf $(OBJDIR)

/* common/decodePkg.sv */
package decodePkg;

    localparam int XLEN_DEFAULT = 64;

    // major opcodes
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_IMM32  = 7'b0011011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_REG32  = 7'b0111011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;

    // alu operand selects
    localparam logic       A_PC   = 1'b0;
    localparam logic       A_RS1  = 1'b1;
    localparam logic [1:0] B_IMM  = 2'd0;
    localparam logic [1:0] B_RS2  = 2'd1;
    localparam logic [1:0] B_FOUR = 2'd2;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rFields;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iFields;

    typedef union packed {
        rFields r;
        iFields i;
    } instrWord;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SLL  = 4'b0001,
        ALU_SLT  = 4'b0010,
        ALU_LUI  = 4'b0011, // passes operand b
        ALU_XOR  = 4'b0100,
        ALU_SRL  = 4'b0101,
        ALU_OR   = 4'b0110,
        ALU_AND  = 4'b0111,
        ALU_SUB  = 4'b1000,
        ALU_SLTU = 4'b1010,
        ALU_REM  = 4'b1100,
        ALU_SRA  = 4'b1101,
        ALU_MUL  = 4'b1110,
        ALU_DIV  = 4'b1111
    } aluOp;

    typedef enum logic [2:0] {
        FMT_NONE = 3'd0,
        FMT_R    = 3'd1,
        FMT_I    = 3'd2,
        FMT_S    = 3'd3,
        FMT_B    = 3'd4,
        FMT_U    = 3'd5,
        FMT_J    = 3'd6
    } immFmt;

    typedef struct packed {
        aluOp       aluCtl;
        logic       aluASrc;   // 0 pc, 1 rs1
        logic [1:0] aluBSrc;   // 0 imm, 1 rs2, 2 const 4
        logic [2:0] branch;
        logic       memWr;
        logic [2:0] memOp;
        logic       memToReg;
        logic       regWr;
        logic       isTruncate;
        logic       isSext;
        logic       illegal;
    } ctrlFields;

    typedef struct packed {
        ctrlFields               ctrl;
        immFmt                   fmt;
        logic [4:0]              rs1;
        logic [4:0]              rs2;
        logic [4:0]              rd;
        logic [XLEN_DEFAULT-1:0] imm;
    } decodeBundle;

endpackage

/* decode/ctrlGen.sv */
`timescale 1ns/1ns
module ctrlGen import decodePkg::*; (
    input  instrWord  instr,
    output ctrlFields ctrl
);

    localparam logic [6:0] F7_ZERO   = 7'b0000000;
    localparam logic [6:0] F7_ALT    = 7'b0100000;
    localparam logic [6:0] F7_MULDIV = 7'b0000001;
    localparam logic [6:0] F7_SHAMT  = 7'b000000?; // shamt[5] free on rv64
    localparam logic [6:0] F7_SRAI   = 7'b010000?;

    ctrlFields base;
    logic      legal;
    logic      isLoad;
    logic      isStore;
    logic      isBranch;
    logic      isWord;

    function automatic ctrlFields row(aluOp alu, logic aSrc, logic [1:0] bSrc,
                                      logic [2:0] br, logic [2:0] mop);
        ctrlFields c;
        c         = '0;
        c.aluCtl  = alu;
        c.aluASrc = aSrc;
        c.aluBSrc = bSrc;
        c.branch  = br;
        c.memOp   = mop;
        return c;
    endfunction

    always_comb begin
        legal = 1'b1;
        casez ({instr.r.funct7, instr.r.funct3, instr.r.opcode})
            {7'b?, 3'b000, OP_IMM}:       base = row(ALU_ADD, A_RS1, B_IMM, 3'd0, 3'd0);
            {7'b?, 3'b010, OP_IMM}:       base = row(ALU_SLT, A_RS1, B_IMM, 3'd0, 3'd0);
            {7'b?, 3'b011, OP_IMM}:       base = row(ALU_SLTU, A_RS1, B_IMM, 3'd0, 3'd0);
            {7'b?, 3'b100, OP_IMM}:       base = row(ALU_XOR, A_RS1, B_IMM, 3'd0, 3'd0);
            {7'b?, 3'b110, OP_IMM}:       base = row(ALU_OR, A_RS1, B_IMM, 3'd0, 3'd0);
            {7'b?, 3'b111, OP_IMM}:       base = row(ALU_AND, A_RS1, B_IMM, 3'd0, 3'd0);
            {F7_SHAMT, 3'b001, OP_IMM}:   base = row(ALU_SLL, A_RS1, B_IMM, 3'd0, 3'd0);
            {F7_SHAMT, 3'b101, OP_IMM}:   base = row(ALU_SRL, A_RS1, B_IMM, 3'd0, 3'd0);
            {F7_SRAI, 3'b101, OP_IMM}:    base = row(ALU_SRA, A_RS1, B_IMM, 3'd0, 3'd0);

            {7'b?, 3'b000, OP_IMM32}:     base = row(ALU_ADD, A_RS1, B_IMM, 3'd0, 3'd0);
            {F7_ZERO, 3'b001, OP_IMM32}:  base = row(ALU_SLL, A_RS1, B_IMM, 3'd0, 3'd0);
            {F7_ZERO, 3'b101, OP_IMM32}:  base = row(ALU_SRL, A_RS1, B_IMM, 3'd0, 3'd0);
            {F7_ALT, 3'b101, OP_IMM32}:   base = row(ALU_SRA, A_RS1, B_IMM, 3'd0, 3'd0);

            {F7_ZERO, 3'b000, OP_REG}:    base = row(ALU_ADD, A_RS1, B_RS2, 3'd0, 3'd0);
            {F7_ALT, 3'b000, OP_REG}:     base = row(ALU_SUB, A_RS1, B_RS2, 3'd0, 3'd0);
            {F7_ZERO, 3'b001, OP_REG}:    base = row(ALU_SLL, A_RS1, B_RS2, 3'd0, 3'd0);
            {F7_ZERO, 3'b010, OP_REG}:    base = row(ALU_SLT, A_RS1, B_RS2, 3'd0, 3'd0);
            {F7_ZERO, 3'b011, OP_REG}:    base = row(ALU_SLTU, A_RS1, B_RS2, 3'd0, 3'd0);
            {F7_ZERO, 3'b100, OP_REG}:    base = row(ALU_XOR, A_RS1, B_RS2, 3'd0, 3'd0);
            {F7_ZERO, 3'b101, OP_REG}:    base = row(ALU_SRL, A_RS1, B_RS2, 3'd0, 3'd0);
            {F7_ALT, 3'b101, OP_REG}:     base = row(ALU_SRA, A_RS1, B_RS2, 3'd0, 3'd0);
            {F7_ZERO, 3'b110, OP_REG}:    base = row(ALU_OR, A_RS1, B_RS2, 3'd0, 3'd0);
            {F7_ZERO, 3'b111, OP_REG}:    base = row(ALU_AND, A_RS1, B_RS2, 3'd0, 3'd0);
            {F7_MULDIV, 3'b000, OP_REG}:  base = row(ALU_MUL, A_RS1, B_RS2, 3'd0, 3'd0);
            {F7_MULDIV, 3'b100, OP_REG}:  base = row(ALU_DIV, A_RS1, B_RS2, 3'd0, 3'd0);
            {F7_MULDIV, 3'b110, OP_REG}:  base = row(ALU_REM, A_RS1, B_RS2, 3'd0, 3'd0);

            {F7_ZERO, 3'b000, OP_REG32}:   base = row(ALU_ADD, A_RS1, B_RS2, 3'd0, 3'd0);
            {F7_ALT, 3'b000, OP_REG32}:    base = row(ALU_SUB, A_RS1, B_RS2, 3'd0, 3'd0);
            {F7_ZERO, 3'b001, OP_REG32}:   base = row(ALU_SLL, A_RS1, B_RS2, 3'd0, 3'd0);
            {F7_ZERO, 3'b101, OP_REG32}:   base = row(ALU_SRL, A_RS1, B_RS2, 3'd0, 3'd0);
            {F7_ALT, 3'b101, OP_REG32}:    base = row(ALU_SRA, A_RS1, B_RS2, 3'd0, 3'd0);
            {F7_MULDIV, 3'b000, OP_REG32}: base = row(ALU_MUL, A_RS1, B_RS2, 3'd0, 3'd0);
            {F7_MULDIV, 3'b100, OP_REG32}: base = row(ALU_DIV, A_RS1, B_RS2, 3'd0, 3'd0);
            {F7_MULDIV, 3'b110, OP_REG32}: base = row(ALU_REM, A_RS1, B_RS2, 3'd0, 3'd0);

            // memOp bit 2 marks a sign-extending load
            {7'b?, 3'b000, OP_LOAD}:      base = row(ALU_ADD, A_RS1, B_IMM, 3'd0, 3'b111);
            {7'b?, 3'b001, OP_LOAD}:      base = row(ALU_ADD, A_RS1, B_IMM, 3'd0, 3'b110);
            {7'b?, 3'b010, OP_LOAD}:      base = row(ALU_ADD, A_RS1, B_IMM, 3'd0, 3'b101);
            {7'b?, 3'b011, OP_LOAD}:      base = row(ALU_ADD, A_RS1, B_IMM, 3'd0, 3'b100);
            {7'b?, 3'b100, OP_LOAD}:      base = row(ALU_ADD, A_RS1, B_IMM, 3'd0, 3'b011);
            {7'b?, 3'b101, OP_LOAD}:      base = row(ALU_ADD, A_RS1, B_IMM, 3'd0, 3'b010);
            {7'b?, 3'b110, OP_LOAD}:      base = row(ALU_ADD, A_RS1, B_IMM, 3'd0, 3'b001);

            {7'b?, 3'b000, OP_STORE}:     base = row(ALU_ADD, A_RS1, B_IMM, 3'd0, 3'b011);
            {7'b?, 3'b001, OP_STORE}:     base = row(ALU_ADD, A_RS1, B_IMM, 3'd0, 3'b010);
            {7'b?, 3'b010, OP_STORE}:     base = row(ALU_ADD, A_RS1, B_IMM, 3'd0, 3'b001);
            {7'b?, 3'b011, OP_STORE}:     base = row(ALU_ADD, A_RS1, B_IMM, 3'd0, 3'b100);

            {7'b?, 3'b000, OP_BRANCH}:    base = row(ALU_SUB, A_RS1, B_RS2, 3'd4, 3'd0); // beq
            {7'b?, 3'b001, OP_BRANCH}:    base = row(ALU_SUB, A_RS1, B_RS2, 3'd5, 3'd0);
            {7'b?, 3'b100, OP_BRANCH}:    base = row(ALU_SLT, A_RS1, B_RS2, 3'd7, 3'd0); // blt
            {7'b?, 3'b101, OP_BRANCH}:    base = row(ALU_SLT, A_RS1, B_RS2, 3'd6, 3'd0);
            {7'b?, 3'b110, OP_BRANCH}:    base = row(ALU_SLTU, A_RS1, B_RS2, 3'd7, 3'd0);
            {7'b?, 3'b111, OP_BRANCH}:    base = row(ALU_SLTU, A_RS1, B_RS2, 3'd6, 3'd0);

            {7'b?, 3'b?, OP_JAL}:         base = row(ALU_ADD, A_PC, B_FOUR, 3'd1, 3'd0); // pc+4 to rd
            {7'b?, 3'b000, OP_JALR}:      base = row(ALU_ADD, A_PC, B_FOUR, 3'd2, 3'd0);
            {7'b?, 3'b?, OP_LUI}:         base = row(ALU_LUI, A_PC, B_IMM, 3'd0, 3'd0);
            {7'b?, 3'b?, OP_AUIPC}:       base = row(ALU_ADD, A_PC, B_IMM, 3'd0, 3'd0);
            default: begin
                legal = 1'b0;
                base  = row(ALU_SLL, A_PC, B_IMM, 3'd0, 3'd0);
            end
        endcase
    end

    assign isLoad   = instr.r.opcode == OP_LOAD;
    assign isStore  = instr.r.opcode == OP_STORE;
    assign isBranch = instr.r.opcode == OP_BRANCH;
    assign isWord   = (instr.r.opcode == OP_IMM32) || (instr.r.opcode == OP_REG32);

    // flags that follow the opcode class alone
    always_comb begin
        ctrl            = base;
        ctrl.memWr      = legal && isStore;
        ctrl.memToReg   = legal && isLoad;
        ctrl.regWr      = legal && !isStore && !isBranch;
        ctrl.isTruncate = legal && isWord;
        ctrl.isSext     = legal && isWord;
        ctrl.illegal    = !legal;
    end

endmodule

/* decode/decodeCommit.sv */
`timescale 1ns/1ns
module decodeCommit import decodePkg::*; #(
    parameter int XLEN = XLEN_DEFAULT
) (
    input  logic             clk,
    input  logic             rstN,
    input  logic             req,
    output logic             ack,
    input  instrWord         instr,
    input  ctrlFields        ctrl,
    input  decodePkg::immFmt immFmt,
    input  logic [XLEN-1:0]  imm,
    output decodeBundle      bundle
);

    decodeBundle nextBundle;
    logic        capture;

    assign capture = req && !ack; // new transfer opens

    always_comb begin
        nextBundle           = '0;
        nextBundle.ctrl      = ctrl;
        nextBundle.ctrl.regWr = ctrl.regWr && (instr.r.rd != 5'd0); // x0 stays zero
        nextBundle.fmt       = immFmt;
        nextBundle.rs1       = instr.r.rs1;
        nextBundle.rs2       = instr.r.rs2;
        nextBundle.rd        = instr.r.rd;
        nextBundle.imm       = XLEN_DEFAULT'($signed(imm));
    end

    // four-phase slave side
    always_ff @(posedge clk) begin
        if (!rstN) begin
            ack    <= 1'b0;
            bundle <= '0;
        end else if (capture) begin
            ack    <= 1'b1;
            bundle <= nextBundle;
        end else if (!req) begin
            ack <= 1'b0;
        end
    end

    ackNeedsReq: assert property (
        @(posedge clk) disable iff (!rstN)
        $rose(ack) |-> $past(req)
    ) else $error("ack rose without a pending req");

    // requester may stretch req while the bundle stays put
    bundleHeld: assert property (
        @(posedge clk) disable iff (!rstN)
        $past(ack && req) |-> $stable(bundle)
    ) else $error("bundle changed during an open transfer");

endmodule

/* decode/immGen.sv */
`timescale 1ns/1ns
module immGen import decodePkg::*; #(
    parameter int XLEN = XLEN_DEFAULT
) (
    input  instrWord         instr,
    output decodePkg::immFmt immFmt,
    output logic [XLEN-1:0]  imm
);

    logic signed [31:0] imm32;

    always_comb begin
        case (instr.i.opcode)
            OP_IMM, OP_IMM32, OP_LOAD, OP_JALR: immFmt = FMT_I;
            OP_REG, OP_REG32:                   immFmt = FMT_R;
            OP_STORE:                           immFmt = FMT_S;
            OP_BRANCH:                          immFmt = FMT_B;
            OP_LUI, OP_AUIPC:                   immFmt = FMT_U;
            OP_JAL:                             immFmt = FMT_J;
            default:                            immFmt = FMT_NONE;
        endcase
    end

    always_comb begin
        case (immFmt)
            FMT_I: begin
                imm32 = {{20{instr[31]}}, instr.i.imm12};
            end
            FMT_S: begin
                imm32 = {{20{instr[31]}}, instr.r.funct7, instr.r.rd};
            end
            FMT_B: begin // byte offset with bit 0 implied
                imm32 = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                         instr[11:8], 1'b0};
            end
            FMT_U: begin
                imm32 = {instr[31:12], 12'b0};
            end
            FMT_J: begin
                imm32 = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                         instr[30:21], 1'b0};
            end
            default: begin
                imm32 = '0;
            end
        endcase
    end

    assign imm = XLEN'(imm32); // sign-extends to xlen

endmodule

/* filelist.f */
+incdir+sim
common/decodePkg.sv
decode/ctrlGen.sv
decode/immGen.sv
decode/decodeCommit.sv
src/decodeStage.sv
sim/decodeStageTb.sv

/* sim/decodeVectors.svh */
// each row holds the encoded word, then the expected alu op, a source, b source, branch,
// memOp, flags {memWr, memToReg, regWr, isTruncate, isSext, illegal}, format and immediate
function automatic void buildTable();
    addRow(encR(7'h00, 5'd3, 5'd2, 3'd0, 5'd1, OP_REG), // add
           ctrlOf(ALU_ADD, A_RS1, B_RS2, 3'd0, 3'd0, 6'b001000), FMT_R, 64'h0);
    addRow(encR(7'h20, 5'd6, 5'd5, 3'd0, 5'd4, OP_REG), // sub
           ctrlOf(ALU_SUB, A_RS1, B_RS2, 3'd0, 3'd0, 6'b001000), FMT_R, 64'h0);
    addRow(encR(7'h00, 5'd2, 5'd1, 3'd0, 5'd0, OP_REG), // add into x0
           ctrlOf(ALU_ADD, A_RS1, B_RS2, 3'd0, 3'd0, 6'b000000), FMT_R, 64'h0);
    addRow(encI(12'hFFF, 5'd2, 3'd0, 5'd1, OP_IMM), // addi -1
           ctrlOf(ALU_ADD, A_RS1, B_IMM, 3'd0, 3'd0, 6'b001000), FMT_I, 64'hFFFF_FFFF_FFFF_FFFF);
    addRow(encI(12'h7F0, 5'd8, 3'd7, 5'd7, OP_IMM), // andi
           ctrlOf(ALU_AND, A_RS1, B_IMM, 3'd0, 3'd0, 6'b001000), FMT_I, 64'h7F0);
    addRow(encI(12'h005, 5'd10, 3'd3, 5'd9, OP_IMM), // sltiu
           ctrlOf(ALU_SLTU, A_RS1, B_IMM, 3'd0, 3'd0, 6'b001000), FMT_I, 64'h5);
    addRow(encI(12'h021, 5'd4, 3'd1, 5'd3, OP_IMM), // slli by 33
           ctrlOf(ALU_SLL, A_RS1, B_IMM, 3'd0, 3'd0, 6'b001000), FMT_I, 64'h21);
    addRow(encI(12'h403, 5'd10, 3'd5, 5'd9, OP_IMM), // srai
           ctrlOf(ALU_SRA, A_RS1, B_IMM, 3'd0, 3'd0, 6'b001000), FMT_I, 64'h403);
    addRow(encR(7'h00, 5'd3, 5'd2, 3'd5, 5'd1, OP_REG), // srl
           ctrlOf(ALU_SRL, A_RS1, B_RS2, 3'd0, 3'd0, 6'b001000), FMT_R, 64'h0);
    addRow(encI(12'hFF8, 5'd12, 3'd3, 5'd11, OP_LOAD), // ld
           ctrlOf(ALU_ADD, A_RS1, B_IMM, 3'd0, 3'b100, 6'b011000), FMT_I, 64'hFFFF_FFFF_FFFF_FFF8);
    addRow(encI(12'h004, 5'd14, 3'd4, 5'd13, OP_LOAD), // lbu
           ctrlOf(ALU_ADD, A_RS1, B_IMM, 3'd0, 3'b011, 6'b011000), FMT_I, 64'h4);
    addRow(encR(7'h00, 5'd5, 5'd6, 3'd3, 5'd16, OP_STORE), // sd
           ctrlOf(ALU_ADD, A_RS1, B_IMM, 3'd0, 3'b100, 6'b100000), FMT_S, 64'h10);
    addRow(encR(7'h7F, 5'd7, 5'd8, 3'd0, 5'd31, OP_STORE), // sb -1
           ctrlOf(ALU_ADD, A_RS1, B_IMM, 3'd0, 3'b011, 6'b100000), FMT_S, 64'hFFFF_FFFF_FFFF_FFFF);
    addRow(encR(7'h00, 5'd2, 5'd1, 3'd0, 5'd8, OP_BRANCH), // beq +8
           ctrlOf(ALU_SUB, A_RS1, B_RS2, 3'd4, 3'd0, 6'b000000), FMT_B, 64'h8);
    addRow(encR(7'h7F, 5'd4, 5'd3, 3'd6, 5'd29, OP_BRANCH), // bltu -4
           ctrlOf(ALU_SLTU, A_RS1, B_RS2, 3'd7, 3'd0, 6'b000000), FMT_B, 64'hFFFF_FFFF_FFFF_FFFC);
    addRow(encR(7'h00, 5'd6, 5'd5, 3'd5, 5'd16, OP_BRANCH), // bge +16
           ctrlOf(ALU_SLT, A_RS1, B_RS2, 3'd6, 3'd0, 6'b000000), FMT_B, 64'h10);
    addRow(encR(7'h00, 5'd16, 5'd0, 3'd0, 5'd1, OP_JAL), // jal +16
           ctrlOf(ALU_ADD, A_PC, B_FOUR, 3'd1, 3'd0, 6'b001000), FMT_J, 64'h10);
    addRow(encI(12'h000, 5'd5, 3'd0, 5'd1, OP_JALR), // jalr
           ctrlOf(ALU_ADD, A_PC, B_FOUR, 3'd2, 3'd0, 6'b001000), FMT_I, 64'h0);
    addRow(encU(20'h12345, 5'd5, OP_LUI), // lui
           ctrlOf(ALU_LUI, A_PC, B_IMM, 3'd0, 3'd0, 6'b001000), FMT_U, 64'h1234_5000);
    addRow(encU(20'h80000, 5'd6, OP_AUIPC), // auipc with negative upper
           ctrlOf(ALU_ADD, A_PC, B_IMM, 3'd0, 3'd0, 6'b001000), FMT_U, 64'hFFFF_FFFF_8000_0000);
    addRow(encR(7'h00, 5'd9, 5'd8, 3'd0, 5'd7, OP_REG32), // addw
           ctrlOf(ALU_ADD, A_RS1, B_RS2, 3'd0, 3'd0, 6'b001110), FMT_R, 64'h0);
    addRow(encI(12'hFFE, 5'd8, 3'd0, 5'd7, OP_IMM32), // addiw -2
           ctrlOf(ALU_ADD, A_RS1, B_IMM, 3'd0, 3'd0, 6'b001110), FMT_I, 64'hFFFF_FFFF_FFFF_FFFE);
    addRow(encR(7'h20, 5'd9, 5'd8, 3'd5, 5'd7, OP_REG32), // sraw
           ctrlOf(ALU_SRA, A_RS1, B_RS2, 3'd0, 3'd0, 6'b001110), FMT_R, 64'h0);
    addRow(encR(7'h01, 5'd12, 5'd11, 3'd0, 5'd10, OP_REG), // mul
           ctrlOf(ALU_MUL, A_RS1, B_RS2, 3'd0, 3'd0, 6'b001000), FMT_R, 64'h0);
    addRow(encR(7'h01, 5'd12, 5'd11, 3'd4, 5'd10, OP_REG), // div
           ctrlOf(ALU_DIV, A_RS1, B_RS2, 3'd0, 3'd0, 6'b001000), FMT_R, 64'h0);
    addRow(encR(7'h01, 5'd12, 5'd11, 3'd6, 5'd10, OP_REG32), // remw
           ctrlOf(ALU_REM, A_RS1, B_RS2, 3'd0, 3'd0, 6'b001110), FMT_R, 64'h0);
    addRow(encI(12'h000, 5'd0, 3'd0, 5'd1, 7'b1110011), // system opcode is not supported
           ctrlOf(ALU_SLL, A_PC, B_IMM, 3'd0, 3'd0, 6'b000001), FMT_NONE, 64'h0);
    addRow(encR(7'h01, 5'd3, 5'd2, 3'd1, 5'd1, OP_REG), // mulh is not in the list
           ctrlOf(ALU_SLL, A_PC, B_IMM, 3'd0, 3'd0, 6'b000001), FMT_R, 64'h0);
endfunction

/* sim/decodeStageTb.sv */
`timescale 1ns/1ns
module decodeStageTb import decodePkg::*; ();

    localparam int CLK_HALF     = 4;
    localparam int MAX_ROWS     = 32;
    localparam int RAND_PER_FMT = 6;

    typedef struct packed {
        instrWord                word;
        ctrlFields               ctrl;
        immFmt                   fmt;
        logic [XLEN_DEFAULT-1:0] imm;
    } vecRow;

    logic        clk;
    logic        rstN;
    logic        req;
    instrWord    instr;
    logic        ack;
    decodeBundle bundle;

    vecRow       vectors [MAX_ROWS];
    int          rowCount;
    int          cycleCount;
    int          cycleLimit;
    logic [31:0] rngState;

    decodeStage #(
        .XLEN (XLEN_DEFAULT)
    ) decodeStage_inst (
        .clk    (clk),
        .rstN   (rstN),
        .req    (req),
        .instr  (instr),
        .ack    (ack),
        .bundle (bundle)
    );

    initial clk = 1'b0;
    always #CLK_HALF clk = ~clk;

    task automatic abortRun();
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > cycleLimit) begin
            $display("timeout: the run went past %0d cycles", cycleLimit);
            abortRun();
        end
    end

    function automatic instrWord encR(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd, input logic [6:0] op);
        instrWord w;
        w = {f7, rs2, rs1, f3, rd, op};
        return w;
    endfunction

    function automatic instrWord encI(input logic [11:0] imm12, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [6:0] op);
        instrWord w;
        w = {imm12, rs1, f3, rd, op};
        return w;
    endfunction

    function automatic instrWord encU(input logic [19:0] upper, input logic [4:0] rd,
                                      input logic [6:0] op);
        instrWord w;
        w = {upper, rd, op};
        return w;
    endfunction

    function automatic ctrlFields ctrlOf(input aluOp alu, input logic aSrc,
                                         input logic [1:0] bSrc, input logic [2:0] br,
                                         input logic [2:0] mop, input logic [5:0] flags);
        ctrlFields c;
        c.aluCtl  = alu;
        c.aluASrc = aSrc;
        c.aluBSrc = bSrc;
        c.branch  = br;
        c.memOp   = mop;
        {c.memWr, c.memToReg, c.regWr, c.isTruncate, c.isSext, c.illegal} = flags;
        return c;
    endfunction

    function automatic void addRow(input instrWord w, input ctrlFields c, input immFmt f,
                                   input logic [XLEN_DEFAULT-1:0] i);
        vectors[rowCount].word = w;
        vectors[rowCount].ctrl = c;
        vectors[rowCount].fmt  = f;
        vectors[rowCount].imm  = i;
        rowCount = rowCount + 1;
    endfunction

    `include "decodeVectors.svh"

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // immediate as the format rules describe it
    function automatic logic [XLEN_DEFAULT-1:0] immRule(input immFmt f, input logic [31:0] w);
        logic [31:0] v;
        case (f)
            FMT_I:   v = {{20{w[31]}}, w[31:20]};
            FMT_S:   v = {{20{w[31]}}, w[31:25], w[11:7]};
            FMT_B:   v = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            FMT_U:   v = {w[31:12], 12'h000};
            FMT_J:   v = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            default: v = 32'h0;
        endcase
        return {{(XLEN_DEFAULT - 32){v[31]}}, v};
    endfunction

    task automatic checkCtrl(input ctrlFields got, input ctrlFields want, input logic [31:0] word);
        if (got !== want) begin
            $display("[FAIL] %0t bundle.ctrl (instr %h) got %h expected %h", $time, word, got, want);
            abortRun();
        end
    endtask

    task automatic checkFmt(input immFmt got, input immFmt want, input logic [31:0] word);
        if (got !== want) begin
            $display("[FAIL] %0t bundle.fmt (instr %h) got %0d expected %0d", $time, word, got, want);
            abortRun();
        end
    endtask

    task automatic checkImm(input logic [XLEN_DEFAULT-1:0] got, input logic [XLEN_DEFAULT-1:0] want,
                            input logic [31:0] word);
        if (got !== want) begin
            $display("[FAIL] %0t bundle.imm (instr %h) got %h expected %h", $time, word, got, want);
            abortRun();
        end
    endtask

    task automatic checkRegs(input decodeBundle got, input logic [31:0] word);
        if ({got.rs1, got.rs2, got.rd} !== {word[19:15], word[24:20], word[11:7]}) begin
            $display("[FAIL] %0t bundle.rs1/rs2/rd (instr %h) got %0d/%0d/%0d expected %0d/%0d/%0d",
                     $time, word, got.rs1, got.rs2, got.rd, word[19:15], word[24:20], word[11:7]);
            abortRun();
        end
    endtask

    task automatic checkIdle();
        if (ack !== 1'b0) begin
            $display("ack is high around reset although no request was made");
            abortRun();
        end
        checkCtrl(bundle.ctrl, '0, 32'h0);
        checkFmt(bundle.fmt, FMT_NONE, 32'h0);
        checkImm(bundle.imm, '0, 32'h0);
        checkRegs(bundle, 32'h0);
    endtask

    // one four-phase transfer with req held for holdCycles extra cycles
    task automatic transfer(input vecRow want, input bit withCtrl, input int holdCycles);
        decodeBundle first;
        @(negedge clk);
        if (ack !== 1'b0) begin
            $display("ack is high although req has been low for a full cycle");
            abortRun();
        end
        instr = want.word;
        req   = 1'b1;
        @(negedge clk);
        while (ack !== 1'b1) @(negedge clk);
        first = bundle;
        if (withCtrl) checkCtrl(first.ctrl, want.ctrl, want.word);
        checkFmt(first.fmt, want.fmt, want.word);
        checkImm(first.imm, want.imm, want.word);
        checkRegs(first, want.word);
        repeat (holdCycles) begin
            @(negedge clk);
            if (ack !== 1'b1) begin
                $display("ack fell while req was still held high");
                abortRun();
            end
            if (bundle !== first) begin
                $display("[FAIL] %0t bundle got %h expected %h", $time, bundle, first);
                abortRun();
            end
        end
        req = 1'b0;
        @(negedge clk);
        while (ack !== 1'b0) @(negedge clk);
    endtask

    initial begin
        vecRow      want;
        logic [6:0] sweepOps [5];
        immFmt      sweepFmts [5];
        rowCount   = 0;
        cycleCount = 0;
        rngState   = 32'h02402cd1;
        rstN       = 1'b0;
        req        = 1'b0;
        instr      = '0;
        sweepOps   = '{OP_LOAD, OP_STORE, OP_BRANCH, OP_LUI, OP_JAL};
        sweepFmts  = '{FMT_I, FMT_S, FMT_B, FMT_U, FMT_J};
        buildTable();
        cycleLimit = (rowCount + 5 * RAND_PER_FMT) * 6 + 50;

        repeat (4) begin
            @(negedge clk);
            checkIdle();
        end
        rstN = 1'b1;
        @(negedge clk);
        checkIdle(); // first edge out of reset

        for (int n = 0; n < rowCount; n++) begin
            transfer(vectors[n], 1'b1, (n % 7 == 3) ? 3 : 0);
        end

        for (int f = 0; f < 5; f++) begin
            for (int k = 0; k < RAND_PER_FMT; k++) begin
                rngState  = xorshift32(rngState);
                want.word = {rngState[31:7], sweepOps[f]};
                want.ctrl = '0;
                want.fmt  = sweepFmts[f];
                want.imm  = immRule(sweepFmts[f], want.word);
                transfer(want, 1'b0, 0); // control fields not checked here
            end
        end

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* src/decodeStage.sv */
`timescale 1ns/1ns
module decodeStage import decodePkg::*; #(
    parameter int XLEN = XLEN_DEFAULT
) (
    input  logic        clk,
    input  logic        rstN,
    input  logic        req,
    input  instrWord    instr,
    output logic        ack,
    output decodeBundle bundle
);

    ctrlFields        ctrl;
    decodePkg::immFmt fmt;
    logic [XLEN-1:0]  imm;

    ctrlGen ctrlGen_inst (
        .instr (instr),
        .ctrl  (ctrl)
    );

    immGen #(
        .XLEN (XLEN)
    ) immGen_inst (
        .instr  (instr),
        .immFmt (fmt),
        .imm    (imm)
    );

    decodeCommit #(
        .XLEN (XLEN)
    ) decodeCommit_inst (
        .clk    (clk),
        .rstN   (rstN),
        .req    (req),
        .ack    (ack),
        .instr  (instr),
        .ctrl   (ctrl),
        .immFmt (fmt),
        .imm    (imm),
        .bundle (bundle)
    );

endmodule
